// File: bench/memPatterns.hex
// op addr wdata expected_rdata expected_exception
// op: 0 none, 8 lb, 9 lh, A lw, B lbu, C sb, D sh, E sw, F lhu
0 00 00000000 00000000 0
E 00 DEADBEEF 00000000 0
E 04 12345678 00000000 0
A 00 00000000 DEADBEEF 0
A 04 00000000 12345678 0
C 08 000000A1 00000000 0
C 09 FFFFFF72 00000000 0
C 0A 000000C3 00000000 0
C 0B 12345684 00000000 0
A 08 00000000 84C372A1 0
8 08 00000000 FFFFFFA1 0
8 09 00000000 00000072 0
8 0A 00000000 FFFFFFC3 0
8 0B 00000000 FFFFFF84 0
B 08 00000000 000000A1 0
B 09 00000000 00000072 0
B 0A 00000000 000000C3 0
B 0B 00000000 00000084 0
D 0C 0000817E 00000000 0
D 0E FFFF3CD5 00000000 0
9 0C 00000000 FFFF817E 0
F 0C 00000000 0000817E 0
9 0D 00000000 FFFFD581 0
F 0D 00000000 0000D581 0
9 0E 00000000 00003CD5 0
F 0E 00000000 00003CD5 0
9 0F 00000000 00000000 1
F 0F 00000000 00000000 1
A 01 00000000 00000000 1
A 02 00000000 00000000 1
A 03 00000000 00000000 1
E 06 AAAAAAAA 00000000 1
D 07 0000BBBB 00000000 1
A 04 00000000 12345678 0

// File: LsuMem.f
hw/Common.sv
hw/ControllerMem.sv
hw/DataMemory.sv
hw/MemRequestFsm.sv
hw/MemSubsystem.sv
bench/MemChecker.sv
bench/MemSubsystemTb.sv

// File: Bender.yml
package:
  name: LsuMem

sources:
  - hw/Common.sv
  - hw/ControllerMem.sv
  - hw/DataMemory.sv
  - hw/MemRequestFsm.sv
  - hw/MemSubsystem.sv
  - target: simulation
    files:
      - bench/MemChecker.sv
      - bench/MemSubsystemTb.sv

// File: bench/MemSubsystemTb.sv
`timescale 1ns/1ps

module MemSubsystemTb;
  import Common::*;

  localparam int ClkPeriod   = 100;
  localparam int DriveDelay  = 5;
  localparam int MaxPatterns = 64;
  localparam int PatWords    = 5;   // Columns per pattern line

  logic  clk;
  logic  rstN;
  logic  req;
  logic  ack;
  logic  loaded;
  MemReq reqData;
  MemRsp rspData;
  MemRsp expRsp;
  int    patCount;
  Uint32 patMem [MaxPatterns*PatWords];

  MemSubsystem u_MemSubsystem (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .reqData (reqData),
    .ack     (ack),
    .rspData (rspData)
  );

  MemChecker u_MemChecker (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .ack     (ack),
    .reqData (reqData),
    .rspData (rspData),
    .expRsp  (expRsp)
  );

  always #(ClkPeriod/2) clk = ~clk;

  // One full four-phase transfer for pattern idx
  task automatic runAccess(input int idx);
    int base;
    base = idx * PatWords;
    @(posedge clk);
    #DriveDelay;
    reqData.op        = MemInstType'(patMem[base][3:0]);
    reqData.addr      = patMem[base+1][MemAddrBits-1:0];
    reqData.wdata     = patMem[base+2];
    expRsp.rdata      = patMem[base+3];
    expRsp.exception  = patMem[base+4][0];
    req               = 1'b1;
    wait (ack === 1'b1);
    repeat ((idx % 8 == 3) ? 3 : 0) @(posedge clk);  // Back-pressure on a few entries
    @(posedge clk);
    #DriveDelay;
    req = 1'b0;
    wait (ack === 1'b0);
  endtask

  initial begin
    clk      = 1'b0;
    rstN     = 1'b0;
    req      = 1'b0;
    reqData  = '0;
    expRsp   = '0;
    loaded   = 1'b0;
    patCount = 0;
    $readmemh("bench/memPatterns.hex", patMem);
    while (patCount < MaxPatterns && !$isunknown(patMem[patCount*PatWords])) begin
      patCount++;
    end
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    #DriveDelay;
    rstN = 1'b1;
    for (int i = 0; i < patCount; i++) begin
      runAccess(i);
    end
    repeat (2) @(posedge clk);
    if (u_MemChecker.accessCount != patCount) begin
      $display("Only %0d of %0d accesses got a response", u_MemChecker.accessCount, patCount);
    end
    $display("Summary: %0d passed, %0d failed, %0d protocol errors, %0d patterns",
             u_MemChecker.passCount, u_MemChecker.failCount, u_MemChecker.protoErrors,
             patCount);
    if (patCount > 0 && u_MemChecker.failCount == 0 && u_MemChecker.protoErrors == 0 &&
        u_MemChecker.accessCount == patCount) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Budget of ten cycles per access plus reset and drain
  initial begin
    wait (loaded);
    #((patCount * 10 + 20) * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", patCount * 10 + 20);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: bench/MemChecker.sv
`timescale 1ns/1ps

module MemChecker (
  input logic          clk,
  input logic          rstN,
  input logic          req,
  input logic          ack,
  input Common::MemReq reqData,
  input Common::MemRsp rspData,
  input Common::MemRsp expRsp
);
  import Common::*;

  // ack loads two edges after req is taken and is read back one edge later
  localparam int AckSeenEdge = 3;

  int    passCount;
  int    failCount;
  int    protoErrors;
  int    accessCount;
  int    edgeCount;      // Edges since req was taken
  int    resetEdges;     // Edges seen with reset held
  logic  busy;
  logic  ackPrev;
  logic  reqPrev;
  MemReq reqHeld;
  MemRsp expHeld;
  MemRsp rspHeld;        // Response as first seen with ack

  initial begin
    passCount   = 0;
    failCount   = 0;
    protoErrors = 0;
    accessCount = 0;
    edgeCount   = 0;
    resetEdges  = 0;
  end

  task automatic protocolError(input string what);
    protoErrors++;
    $display("Protocol error at %0t ns: %s", $time, what);
  endtask

  task automatic compareResponse();
    logic ok;
    ok = 1'b1;
    accessCount++;
    if (rspData.rdata !== expHeld.rdata) begin
      ok = 1'b0;
      $display("FAIL access %0d op 0x%h addr 0x%02h: rspData.rdata expected 0x%08h got 0x%08h",
               accessCount, reqHeld.op, reqHeld.addr, expHeld.rdata, rspData.rdata);
    end
    if (rspData.exception !== expHeld.exception) begin
      ok = 1'b0;
      $display("FAIL access %0d op 0x%h addr 0x%02h: rspData.exception expected 0x%h got 0x%h",
               accessCount, reqHeld.op, reqHeld.addr, expHeld.exception, rspData.exception);
    end
    if (ok) begin
      passCount++;
      $display("PASS access %0d op 0x%h addr 0x%02h rdata 0x%08h exception %0d",
               accessCount, reqHeld.op, reqHeld.addr, rspData.rdata, rspData.exception);
    end else begin
      failCount++;
    end
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      // Outputs are settled once one reset edge has passed
      if (resetEdges > 0 && (ack !== 1'b0 || rspData !== '0)) begin
        protocolError("ack or response not cleared while reset is held");
      end
      resetEdges++;
      busy    = 1'b0;
      ackPrev = 1'b0;
      reqPrev = 1'b0;
    end else begin
      if (busy) begin
        edgeCount++;
      end
      if (!busy && req && !ack) begin  // DUT takes the request on this edge
        busy      = 1'b1;
        edgeCount = 0;
        reqHeld   = reqData;
        expHeld   = expRsp;
      end
      if (ack && !ackPrev) begin
        if (!busy) begin
          protocolError("ack rose with no request pending");
        end else begin
          if (edgeCount != AckSeenEdge) begin
            protocolError($sformatf("ack came %0d cycles after req was taken instead of 2",
                                    edgeCount - 1));
          end
          rspHeld = rspData;
          compareResponse();
        end
      end
      if (ack && ackPrev && rspData !== rspHeld) begin
        protocolError("response changed while ack was held");
      end
      if (ack && ackPrev && !reqPrev) begin
        protocolError("ack still high one cycle after req dropped");
      end
      if (!ack && ackPrev) begin
        if (reqPrev) begin
          protocolError("ack dropped while req was still high");
        end
        busy = 1'b0;
      end
      ackPrev = ack;
      reqPrev = req;
    end
  end

endmodule

// File: hw/MemSubsystem.sv
`timescale 1ns/1ps

module MemSubsystem (
  input  logic          clk,
  input  logic          rstN,
  input  logic          req,
  input  Common::MemReq reqData,
  output logic          ack,
  output Common::MemRsp rspData
);
  import Common::*;

  MemInstType ctrlOp;
  logic [1:0] ctrlAddr;
  Uint32      ctrlWdata;
  Uint32      ctrlDataRead;
  Uint32      ctrlDataMemIn;
  logic [3:0] ctrlMask;
  logic       ctrlRead;
  logic       ctrlWrite;
  logic       ctrlException;
  RamPort     ramPort;
  Uint32      dataMemOut;   // Raw RAM word back to the controller

  MemRequestFsm u_MemRequestFsm (
    .clk           (clk),
    .rstN          (rstN),
    .req           (req),
    .reqData       (reqData),
    .ack           (ack),
    .rspData       (rspData),
    .ctrlOp        (ctrlOp),
    .ctrlAddr      (ctrlAddr),
    .ctrlWdata     (ctrlWdata),
    .ctrlDataRead  (ctrlDataRead),
    .ctrlDataMemIn (ctrlDataMemIn),
    .ctrlMask      (ctrlMask),
    .ctrlRead      (ctrlRead),
    .ctrlWrite     (ctrlWrite),
    .ctrlException (ctrlException),
    .ramPort       (ramPort)
  );

  ControllerMem u_ControllerMem (
    .address    (ctrlAddr),
    .dataMemOut (dataMemOut),
    .writeData  (ctrlWdata),
    .instType   (ctrlOp),
    .dataRead   (ctrlDataRead),
    .dataMemIn  (ctrlDataMemIn),
    .maskByte   (ctrlMask),
    .read       (ctrlRead),
    .write      (ctrlWrite),
    .exception  (ctrlException)
  );

  DataMemory u_DataMemory (
    .clk        (clk),
    .ramPort    (ramPort),
    .dataMemOut (dataMemOut)
  );

endmodule

// File: hw/MemRequestFsm.sv
`timescale 1ns/1ps

module MemRequestFsm (
  input  logic               clk,
  input  logic               rstN,
  input  logic               req,
  input  Common::MemReq      reqData,
  output logic               ack,
  output Common::MemRsp      rspData,
  output Common::MemInstType ctrlOp,
  output logic [1:0]         ctrlAddr,
  output Common::Uint32      ctrlWdata,
  input  Common::Uint32      ctrlDataRead,
  input  Common::Uint32      ctrlDataMemIn,
  input  logic [3:0]         ctrlMask,
  input  logic               ctrlRead,
  input  logic               ctrlWrite,
  input  logic               ctrlException,
  output Common::RamPort     ramPort
);
  import Common::*;

  typedef enum logic [1:0] {
    Idle,
    Access,
    Respond
  } FsmState;

  FsmState state;
  MemReq   reqQ;      // Request held for the whole transaction
  logic    accessPhase;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state   <= Idle;
      reqQ    <= '{op: MemNone, addr: '0, wdata: '0};
      ack     <= 1'b0;
      rspData <= '0;
    end else begin
      case (state)
        Idle: begin
          if (req) begin
            reqQ  <= reqData;
            state <= Access;
          end
        end
        Access: begin
          state <= Respond;  // RAM samples its port on this edge
        end
        Respond: begin
          if (!ack) begin
            rspData <= '{rdata: ctrlDataRead, exception: ctrlException};
            ack     <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;   // Requester closed the handshake
            state <= Idle;
          end
        end
        default: begin
          state <= Idle;
        end
      endcase
    end
  end

  assign ctrlOp    = reqQ.op;
  assign ctrlAddr  = reqQ.addr[1:0];
  assign ctrlWdata = reqQ.wdata;

  // Strobes only live for the single Access cycle
  assign accessPhase = (state == Access);
  assign ramPort = '{
    wordAddr:  reqQ.addr[MemAddrBits-1:2],
    writeData: ctrlDataMemIn,
    maskByte:  ctrlMask,
    write:     ctrlWrite && accessPhase,
    read:      ctrlRead && accessPhase
  };

  assert property (@(posedge clk) disable iff (!rstN) ack |-> state == Respond)
    else $error("MemRequestFsm: ack high outside Respond");

  // Ack register set on the second edge after req is taken
  assert property (@(posedge clk) disable iff (!rstN)
                   (state == Idle && req) |-> ##3 $rose(ack))
    else $error("MemRequestFsm: ack did not follow req by two cycles");

endmodule

// File: hw/DataMemory.sv
`timescale 1ns/1ps

module DataMemory (
  input  logic           clk,
  input  Common::RamPort ramPort,
  output Common::Uint32  dataMemOut
);
  import Common::*;

  Uint32 mem [MemDepthWords];

  always_ff @(posedge clk) begin
    if (ramPort.write) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (ramPort.maskByte[lane]) begin
          mem[ramPort.wordAddr][lane*8 +: 8] <= ramPort.writeData[lane*8 +: 8];
        end
      end
    end
    if (ramPort.read) begin
      dataMemOut <= mem[ramPort.wordAddr];  // Valid one cycle after read
    end
  end

  // Misaligned stores must be dropped upstream, not reach here as empty writes
  assert property (@(posedge clk) ramPort.write |-> ramPort.maskByte != 4'b0000)
    else $error("DataMemory: write with empty byte mask at word %0d", ramPort.wordAddr);

endmodule

// File: hw/ControllerMem.sv
`timescale 1ns/1ps

module ControllerMem (
  input  logic [1:0]         address,
  input  Common::Uint32      dataMemOut,
  input  Common::Uint32      writeData,
  input  Common::MemInstType instType,
  output Common::Uint32      dataRead,
  output Common::Uint32      dataMemIn,
  output logic [3:0]         maskByte,
  output logic               read,
  output logic               write,
  output logic               exception
);
  import Common::*;

  logic [4:0] laneShift;
  Uint32      shiftedOut;
  Uint32      storeByte;
  Uint32      storeHalf;

  assign laneShift  = {address, 3'b000};              // Byte offset in bits
  assign shiftedOut = dataMemOut >> laneShift;        // Addressed byte moved to lane 0
  assign storeByte  = 32'(writeData[7:0]) << laneShift;
  assign storeHalf  = 32'(writeData[15:0]) << laneShift;

  always_comb begin
    dataRead  = '0;  // Also the result of every store and fault
    dataMemIn = '0;
    maskByte  = '0;
    read      = 1'b0;
    write     = 1'b0;
    exception = 1'b0;

    case (instType)
      MemLb: begin
        read     = 1'b1;
        dataRead = 32'($signed(shiftedOut[7:0]));
      end
      MemLbu: begin
        read     = 1'b1;
        dataRead = 32'(shiftedOut[7:0]);
      end
      MemLh: begin
        if (address == 2'd3) begin
          exception = 1'b1;  // Half would cross the word
        end else begin
          read     = 1'b1;
          dataRead = 32'($signed(shiftedOut[15:0]));
        end
      end
      MemLhu: begin
        if (address == 2'd3) begin
          exception = 1'b1;
        end else begin
          read     = 1'b1;
          dataRead = 32'(shiftedOut[15:0]);
        end
      end
      MemLw: begin
        if (address != 2'd0) begin
          exception = 1'b1;
        end else begin
          read     = 1'b1;
          dataRead = dataMemOut;
        end
      end
      MemSb: begin
        write     = 1'b1;
        maskByte  = 4'b0001 << address;
        dataMemIn = storeByte;
      end
      MemSh: begin
        if (address == 2'd3) begin
          exception = 1'b1;  // Mask stays zero, nothing written
        end else begin
          write     = 1'b1;
          maskByte  = 4'b0011 << address;
          dataMemIn = storeHalf;
        end
      end
      MemSw: begin
        if (address != 2'd0) begin
          exception = 1'b1;
        end else begin
          write     = 1'b1;
          maskByte  = 4'b1111;
          dataMemIn = writeData;
        end
      end
      default: begin
        // MemNone leaves every output at its idle value
      end
    endcase
  end

  // A faulting op never reaches the RAM, and no op both reads and writes
  always_comb begin
    assert final ($isunknown(instType) ||
                  (!(read && write) && !(exception && (read || write))))
      else $error("ControllerMem: access strobes conflict for op %s", instType.name());
  end

endmodule

// File: hw/Common.sv
package Common;

  // Memory geometry; word address width comes from the depth
  localparam int MemDepthWords = 64;
  localparam int MemWordBits   = $clog2(MemDepthWords);
  localparam int MemAddrBits   = MemWordBits + 2;  // Plus two byte-offset bits

  typedef logic [31:0] Uint32;

  // Bit 3 marks a valid access, bit 2 a store, bits 1:0 the size
  // Unsigned half sits in the spare store slot
  typedef enum logic [3:0] {
    MemNone = 4'b0000,
    MemLb   = 4'b1000,
    MemLh   = 4'b1001,
    MemLw   = 4'b1010,
    MemLbu  = 4'b1011,
    MemSb   = 4'b1100,
    MemSh   = 4'b1101,
    MemSw   = 4'b1110,
    MemLhu  = 4'b1111
  } MemInstType;

  typedef struct packed {
    MemInstType             op;
    logic [MemAddrBits-1:0] addr;   // Byte address
    Uint32                  wdata;
  } MemReq;

  typedef struct packed {
    Uint32 rdata;
    logic  exception;
  } MemRsp;

  typedef struct packed {
    logic [MemWordBits-1:0] wordAddr;
    Uint32                  writeData;  // Already placed in its byte lanes
    logic [3:0]             maskByte;
    logic                   write;
    logic                   read;
  } RamPort;

endpackage
